/* design/core_defs.svh */
// Core sizing macros

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Operand and result width.
`define DATA_WIDTH 32

// Architectural registers with x0 reading as zero.
`define REG_COUNT 32

// Input buffer entries and the sender's starting credits.
`define IN_DEPTH 4

// Retire records the consumer can hold.
`define OUT_CREDITS 2

`endif

/* design/isa_pkg.sv */
// Instruction set encodings

`include "core_defs.svh"

package isa_pkg;

    typedef logic [`DATA_WIDTH-1:0]         data_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10                   // LUI style.
    } aluop_t;

    typedef enum logic [2:0] {
        CFU_NONE = 3'd0,
        CFU_EQ   = 3'd1,
        CFU_NE   = 3'd2,
        CFU_LT   = 3'd3,
        CFU_GE   = 3'd4,
        CFU_LTU  = 3'd5,
        CFU_GEU  = 3'd6,
        CFU_JUMP = 3'd7
    } cfuop_t;

    typedef struct packed {
        data_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        data_t     imm;
        aluop_t    aluop;
        cfuop_t    cfuop;
        logic      opr_a_sel;               // 1 selects pc.
        logic      opr_b_sel;               // 1 selects imm.
        logic      rf_en;
    } instr_t;

endpackage

/* design/pipe_pkg.sv */
// Pipeline stage records

`include "core_defs.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        data_t     pc;
        data_t     pc4;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        data_t     opr_a;                   // rs1 value from the register file.
        data_t     opr_b;                   // rs2 value from the register file.
        data_t     imm;
        aluop_t    aluop;
        cfuop_t    cfuop;
        logic      opr_a_sel;
        logic      opr_b_sel;
        logic      rf_en;
    } ex_stage_in_t;

    typedef struct packed {
        data_t     opr_res;
        reg_addr_t rd;
        data_t     pc4;
        logic      rf_en;
        logic      br_taken;
        data_t     br_target;
    } ex_stage_out_t;

    // One pending register write qualified by its stage valid.
    typedef struct packed {
        logic      rf_en;
        reg_addr_t rd;
        data_t     data;
    } fwd_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rf_en;
        data_t     result;
        logic      br_taken;
        data_t     br_target;
    } retire_t;

endpackage

/* design/credit_fifo.sv */
// Credit returning FIFO

`timescale 1ns/1ns

module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop;                  // One credit back per entry freed.
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

/* design/alu.sv */
// Arithmetic and logic unit

`timescale 1ns/1ns

`include "core_defs.svh"

module alu
    import isa_pkg::*;
#(
    parameter int DATA_WIDTH = `DATA_WIDTH
) (
    input  aluop_t                aluop,
    input  logic [DATA_WIDTH-1:0] opr_a,
    input  logic [DATA_WIDTH-1:0] opr_b,
    output logic [DATA_WIDTH-1:0] opr_result
);

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = opr_b[SHAMT_W-1:0];     // Upper bits of B ignored.
    assign lt_s  = $signed(opr_a) < $signed(opr_b);
    assign lt_u  = opr_a < opr_b;

    always_comb
    begin
        case (aluop)
            ALU_ADD:   opr_result = opr_a + opr_b;
            ALU_SUB:   opr_result = opr_a - opr_b;
            ALU_SLL:   opr_result = opr_a << shamt;
            ALU_SLT:   opr_result = {{(DATA_WIDTH-1){1'b0}}, lt_s};
            ALU_SLTU:  opr_result = {{(DATA_WIDTH-1){1'b0}}, lt_u};
            ALU_XOR:   opr_result = opr_a ^ opr_b;
            ALU_SRL:   opr_result = opr_a >> shamt;
            ALU_SRA:   opr_result = $unsigned($signed(opr_a) >>> shamt);
            ALU_OR:    opr_result = opr_a | opr_b;
            ALU_AND:   opr_result = opr_a & opr_b;
            ALU_PASSB: opr_result = opr_b;
            default:   opr_result = '0;
        endcase
    end

endmodule

/* design/cfu.sv */
// Branch condition unit

`timescale 1ns/1ns

`include "core_defs.svh"

module cfu
    import isa_pkg::*;
#(
    parameter int DATA_WIDTH = `DATA_WIDTH
) (
    input  cfuop_t                cfuop,
    input  logic [DATA_WIDTH-1:0] opr_a,
    input  logic [DATA_WIDTH-1:0] opr_b,
    output logic                  br_taken
);

    always_comb
    begin
        case (cfuop)
            CFU_EQ:   br_taken = (opr_a == opr_b);
            CFU_NE:   br_taken = (opr_a != opr_b);
            CFU_LT:   br_taken = ($signed(opr_a) <  $signed(opr_b));
            CFU_GE:   br_taken = ($signed(opr_a) >= $signed(opr_b));
            CFU_LTU:  br_taken = (opr_a <  opr_b);
            CFU_GEU:  br_taken = (opr_a >= opr_b);
            CFU_JUMP: br_taken = 1'b1;
            default:  br_taken = 1'b0;      // Also CFU_NONE.
        endcase
    end

endmodule

/* design/id_stage.sv */
// Decode stage

`timescale 1ns/1ns

`include "core_defs.svh"

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         advance,
    input  logic         instr_valid,
    input  instr_t       instr,
    input  fwd_t         wb_fwd,
    output logic         ex_valid,
    output ex_stage_in_t ex_in
);

    data_t        rf [`REG_COUNT];
    logic         rf_we;
    data_t        rs1_val;
    data_t        rs2_val;
    ex_stage_in_t dec;

    // Write-through read so a same-cycle write is seen.
    function automatic data_t rf_read(input reg_addr_t addr, input data_t stored,
                                      input logic we, input fwd_t wr);
        data_t val;
        if (addr == '0)
            val = '0;
        else if (we && (wr.rd == addr))
            val = wr.data;
        else
            val = stored;
        return val;
    endfunction

    assign rf_we   = advance && wb_fwd.rf_en && (wb_fwd.rd != '0);
    assign rs1_val = rf_read(instr.rs1, rf[instr.rs1], rf_we, wb_fwd);
    assign rs2_val = rf_read(instr.rs2, rf[instr.rs2], rf_we, wb_fwd);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                rf[i] <= '0;
        end
        else if (rf_we)
        begin
            rf[wb_fwd.rd] <= wb_fwd.data;
        end
    end

    always_comb
    begin
        dec.pc        = instr.pc;
        dec.pc4       = instr.pc + 'd4;
        dec.rs1       = instr.rs1;
        dec.rs2       = instr.rs2;
        dec.rd        = instr.rd;
        dec.opr_a     = rs1_val;
        dec.opr_b     = rs2_val;
        dec.imm       = instr.imm;
        dec.aluop     = instr.aluop;
        dec.cfuop     = instr.cfuop;
        dec.opr_a_sel = instr.opr_a_sel;
        dec.opr_b_sel = instr.opr_b_sel;
        dec.rf_en     = instr.rf_en;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ex_valid <= 1'b0;
        else if (advance)
            ex_valid <= instr_valid;        // Empty buffer gives a bubble.
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            ex_in <= dec;
    end

endmodule

/* design/ex_stage.sv */
// Execute stage

`timescale 1ns/1ns

`include "core_defs.svh"

module ex_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          advance,
    input  logic          in_valid,
    input  ex_stage_in_t  ex_in,
    input  fwd_t          mem_fwd,
    input  fwd_t          wb_fwd,
    output logic          out_valid,
    output ex_stage_out_t ex_out
);

    data_t         for_opr_a;
    data_t         for_opr_b;
    data_t         opr_a;
    data_t         opr_b;
    data_t         opr_res;
    logic          br_taken;
    ex_stage_out_t exr;

    // Youngest pending write wins.
    function automatic data_t fwd_pick(input reg_addr_t rs, input data_t rf_val,
                                       input fwd_t near, input fwd_t far);
        data_t val;
        if (near.rf_en && (near.rd == rs) && (rs != '0))
            val = near.data;
        else if (far.rf_en && (far.rd == rs) && (rs != '0))
            val = far.data;
        else
            val = rf_val;
        return val;
    endfunction

    assign for_opr_a = fwd_pick(ex_in.rs1, ex_in.opr_a, mem_fwd, wb_fwd);
    assign for_opr_b = fwd_pick(ex_in.rs2, ex_in.opr_b, mem_fwd, wb_fwd);

    assign opr_a = ex_in.opr_a_sel ? ex_in.pc  : for_opr_a;    // AUIPC and branches.
    assign opr_b = ex_in.opr_b_sel ? ex_in.imm : for_opr_b;

    alu #(
        .DATA_WIDTH (`DATA_WIDTH)
    ) i_alu (
        .aluop      (ex_in.aluop),
        .opr_a      (opr_a      ),
        .opr_b      (opr_b      ),
        .opr_result (opr_res    )
    );

    cfu #(
        .DATA_WIDTH (`DATA_WIDTH)
    ) i_cfu (
        .cfuop      (ex_in.cfuop),
        .opr_a      (for_opr_a  ),
        .opr_b      (for_opr_b  ),
        .br_taken   (br_taken   )
    );

    assign exr.opr_res   = opr_res;
    assign exr.rd        = ex_in.rd;
    assign exr.pc4       = ex_in.pc4;
    assign exr.rf_en     = ex_in.rf_en;
    assign exr.br_taken  = br_taken;
    assign exr.br_target = opr_res;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (advance)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            ex_out <= exr;
    end

endmodule

/* design/wb_stage.sv */
// Result and write-back stage

`timescale 1ns/1ns

module wb_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          advance,
    input  logic          in_valid,
    input  ex_stage_out_t ex_out,
    output fwd_t          mem_fwd,
    output fwd_t          wb_fwd,
    output logic          ret_valid,
    output retire_t       ret
);

    data_t   res_data;
    logic    wb_valid;
    retire_t wb_q;

    // Taken jumps link pc4.
    assign res_data = ex_out.br_taken ? ex_out.pc4 : ex_out.opr_res;

    assign mem_fwd.rf_en = in_valid & ex_out.rf_en;
    assign mem_fwd.rd    = ex_out.rd;
    assign mem_fwd.data  = res_data;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else if (advance)
            wb_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            wb_q.rd        <= ex_out.rd;
            wb_q.rf_en     <= ex_out.rf_en;
            wb_q.result    <= res_data;
            wb_q.br_taken  <= ex_out.br_taken;
            wb_q.br_target <= ex_out.br_target;
        end
    end

    assign wb_fwd.rf_en = wb_valid & wb_q.rf_en;
    assign wb_fwd.rd    = wb_q.rd;
    assign wb_fwd.data  = wb_q.result;

    assign ret_valid = wb_valid & advance;  // Retires as it leaves the register.
    assign ret       = wb_q;

endmodule

/* design/mini_core.sv */
// Mini core top level

`timescale 1ns/1ns

`include "core_defs.svh"

module mini_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    in_credit,
    output logic    ret_valid,
    output retire_t ret,
    input  logic    ret_credit
);

    localparam int CNT_W = $clog2(`OUT_CREDITS + 1);

    logic             advance;
    logic             fifo_ne;
    logic             pop;
    instr_t           fifo_instr;
    logic             ex_valid;
    ex_stage_in_t     ex_in;
    logic             res_valid;
    ex_stage_out_t    ex_out;
    fwd_t             mem_fwd;
    fwd_t             wb_fwd;
    logic [CNT_W-1:0] out_cnt;
    logic             wb_busy;

    // Stall only when a record waits and the consumer is full.
    assign advance = !(wb_busy && (out_cnt == '0));
    assign pop     = advance & fifo_ne;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_cnt <= CNT_W'(`OUT_CREDITS);
            wb_busy <= 1'b0;
        end
        else
        begin
            out_cnt <= out_cnt - CNT_W'(ret_valid) + CNT_W'(ret_credit);
            if (advance)
                wb_busy <= res_valid;       // Tracks the write-back valid.
        end
    end

    credit_fifo #(
        .payload_t (instr_t   ),
        .DEPTH     (`IN_DEPTH )
    ) i_in_fifo (
        .clk       (clk       ),
        .arst_n    (arst_n    ),
        .push      (in_valid  ),
        .push_data (in_instr  ),
        .pop       (pop       ),
        .pop_data  (fifo_instr),
        .not_empty (fifo_ne   ),
        .credit    (in_credit )
    );

    id_stage i_id_stage (
        .clk         (clk       ),
        .arst_n      (arst_n    ),
        .advance     (advance   ),
        .instr_valid (fifo_ne   ),
        .instr       (fifo_instr),
        .wb_fwd      (wb_fwd    ),
        .ex_valid    (ex_valid  ),
        .ex_in       (ex_in     )
    );

    ex_stage i_ex_stage (
        .clk       (clk      ),
        .arst_n    (arst_n   ),
        .advance   (advance  ),
        .in_valid  (ex_valid ),
        .ex_in     (ex_in    ),
        .mem_fwd   (mem_fwd  ),
        .wb_fwd    (wb_fwd   ),
        .out_valid (res_valid),
        .ex_out    (ex_out   )
    );

    wb_stage i_wb_stage (
        .clk       (clk      ),
        .arst_n    (arst_n   ),
        .advance   (advance  ),
        .in_valid  (res_valid),
        .ex_out    (ex_out   ),
        .mem_fwd   (mem_fwd  ),
        .wb_fwd    (wb_fwd   ),
        .ret_valid (ret_valid),
        .ret       (ret      )
    );

endmodule

/* sim/tb_mini_core.sv */
// Mini core testbench

`timescale 1ns/1ns

`include "core_defs.svh"

module tb_mini_core
    import isa_pkg::*;
    import pipe_pkg::*;
;

    typedef struct packed {
        instr_t  instr;
        retire_t exp;
    } step_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    instr_t      in_instr;
    logic        in_credit;
    logic        ret_valid;
    retire_t     ret;
    logic        ret_credit;

    step_t       tbl[$];
    logic [31:0] ref_regs[`REG_COUNT];
    int          rel_q[$];                  // Cycle at which each held record is freed.
    int          cyc;
    int          limit;
    int          send_idx;
    int          rcv_cnt;
    int          credits;                   // Sender side.
    int          credit_total;
    int          out_avail;                 // Consumer slots the core may still use.
    int          settle;

    mini_core uut (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .in_valid   (in_valid  ),
        .in_instr   (in_instr  ),
        .in_credit  (in_credit ),
        .ret_valid  (ret_valid ),
        .ret        (ret       ),
        .ret_credit (ret_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic add(input int rs1, input int rs2, input int rd, input logic [31:0] imm,
                       input aluop_t aop, input cfuop_t cop, input int a_sel, input int b_sel,
                       input int rf_en);
        step_t s;
        s                 = '0;
        s.instr.pc        = 32'h100 + 32'(4 * tbl.size());
        s.instr.rs1       = reg_addr_t'(rs1);
        s.instr.rs2       = reg_addr_t'(rs2);
        s.instr.rd        = reg_addr_t'(rd);
        s.instr.imm       = imm;
        s.instr.aluop     = aop;
        s.instr.cfuop     = cop;
        s.instr.opr_a_sel = (a_sel != 0);
        s.instr.opr_b_sel = (b_sel != 0);
        s.instr.rf_en     = (rf_en != 0);
        tbl.push_back(s);
    endtask

    // Reference ALU result from the RV32I rules.
    function automatic logic [31:0] alu_ref(input aluop_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0]  s;
        logic [31:0] r;
        s = b[4:0];
        case (op)
            ALU_ADD:   r = a + b;
            ALU_SUB:   r = a + ~b + 32'd1;
            ALU_SLL:   r = a << s;
            ALU_SLT:   r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU:  r = {31'd0, a < b};
            ALU_XOR:   r = a ^ b;
            ALU_SRL:   r = a >> s;
            ALU_SRA:   r = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0);
            ALU_OR:    r = a | b;
            ALU_AND:   r = a & b;
            ALU_PASSB: r = b;
            default:   r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic logic taken_ref(input cfuop_t op, input logic [31:0] a,
                                       input logic [31:0] b);
        logic lt;
        logic tk;
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            CFU_EQ:   tk = (a == b);
            CFU_NE:   tk = (a != b);
            CFU_LT:   tk = lt;
            CFU_GE:   tk = !lt;
            CFU_LTU:  tk = (a < b);
            CFU_GEU:  tk = !(a < b);
            CFU_JUMP: tk = 1'b1;
            default:  tk = 1'b0;
        endcase
        return tk;
    endfunction

    // In-order register model fills in the expected retire records.
    task automatic run_model();
        step_t       s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        tk;
        for (int r = 0; r < `REG_COUNT; r++)
            ref_regs[r] = '0;
        foreach (tbl[i])
        begin
            s   = tbl[i];
            a   = ref_regs[s.instr.rs1];
            b   = ref_regs[s.instr.rs2];
            res = alu_ref(s.instr.aluop, s.instr.opr_a_sel ? s.instr.pc : a,
                          s.instr.opr_b_sel ? s.instr.imm : b);
            tk  = taken_ref(s.instr.cfuop, a, b);
            s.exp.rd        = s.instr.rd;
            s.exp.rf_en     = s.instr.rf_en;
            s.exp.result    = tk ? s.instr.pc + 32'd4 : res;   // Link value on taken.
            s.exp.br_taken  = tk;
            s.exp.br_target = res;
            if (s.instr.rf_en && s.instr.rd != '0)
                ref_regs[s.instr.rd] = s.exp.result;
            tbl[i] = s;
        end
    endtask

    task automatic check_record(input int idx);
        retire_t e;
        e = tbl[idx].exp;
        check_val($sformatf("record %0d rd", idx), 32'(ret.rd), 32'(e.rd));
        check_val($sformatf("record %0d rf_en", idx), 32'(ret.rf_en), 32'(e.rf_en));
        check_val($sformatf("record %0d result", idx), ret.result, e.result);
        check_val($sformatf("record %0d br_taken", idx), 32'(ret.br_taken), 32'(e.br_taken));
        check_val($sformatf("record %0d br_target", idx), ret.br_target, e.br_target);
    endtask

    // Samples the DUT on a falling edge, then drives the next inputs.
    task automatic step_cycle();
        cyc++;
        if (cyc > limit)
        begin
            $display("Timeout: %0d of %0d records retired after %0d cycles",
                     rcv_cnt, tbl.size(), cyc);
            abort_run();
        end
        if (in_credit)
        begin
            credits++;
            credit_total++;
        end
        if (credits > `IN_DEPTH)
        begin
            $display("Error at %0t: the core returned more input credits than it took", $time);
            abort_run();
        end
        if (ret_valid)
        begin
            if (out_avail == 0)
            begin
                $display("Error at %0t: retire record sent without an output credit", $time);
                abort_run();
            end
            if (rcv_cnt >= tbl.size())
            begin
                $display("Error at %0t: more retire records than instructions", $time);
                abort_run();
            end
            check_record(rcv_cnt);
            rcv_cnt++;
            out_avail--;
            rel_q.push_back(cyc + int'($urandom % 4));
        end
        if (rel_q.size() > 0 && rel_q[0] <= cyc)
        begin
            void'(rel_q.pop_front());
            out_avail++;
            ret_credit = 1'b1;
        end
        else
            ret_credit = 1'b0;
        if (send_idx < tbl.size() && credits > 0)
        begin
            in_valid = 1'b1;
            in_instr = tbl[send_idx].instr;
            send_idx++;
            credits--;
        end
        else
        begin
            in_valid = 1'b0;
            in_instr = '0;
        end
    endtask

    initial
    begin
        void'($urandom(32'h65ce8ffe));
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        ret_credit = 1'b0;
        // Register and immediate ALU operations, x0 handling.
        add(0, 0, 1, 32'h123, ALU_ADD, CFU_NONE, 0, 1, 1);
        add(0, 0, 2, -5, ALU_ADD, CFU_NONE, 0, 1, 1);
        add(0, 0, 3, 32'h8000_0000, ALU_PASSB, CFU_NONE, 0, 1, 1);
        add(1, 2, 4, 0, ALU_ADD, CFU_NONE, 0, 0, 1);
        add(4, 1, 5, 0, ALU_SUB, CFU_NONE, 0, 0, 1);
        add(1, 0, 6, 4, ALU_SLL, CFU_NONE, 0, 1, 1);
        add(2, 1, 7, 0, ALU_SLT, CFU_NONE, 0, 0, 1);
        add(2, 1, 8, 0, ALU_SLTU, CFU_NONE, 0, 0, 1);
        add(3, 0, 9, 3, ALU_SRA, CFU_NONE, 0, 1, 1);
        add(3, 2, 10, 0, ALU_SRL, CFU_NONE, 0, 0, 1);           // Shift by a negative value.
        add(2, 2, 11, 0, ALU_SLL, CFU_NONE, 0, 0, 1);
        add(1, 0, 12, 32'hffff_ff00, ALU_XOR, CFU_NONE, 0, 1, 1);
        add(12, 1, 13, 0, ALU_OR, CFU_NONE, 0, 0, 1);
        add(13, 0, 14, 32'h0f0f, ALU_AND, CFU_NONE, 0, 1, 1);
        add(0, 0, 0, 77, ALU_ADD, CFU_NONE, 0, 1, 1);
        add(0, 0, 15, 0, ALU_ADD, CFU_NONE, 0, 0, 1);
        add(2, 0, 16, -8, ALU_SLT, CFU_NONE, 0, 1, 1);
        add(2, 0, 17, 7, ALU_SLTU, CFU_NONE, 0, 1, 1);
        add(9, 1, 18, 0, ALU_SRA, CFU_NONE, 0, 0, 1);
        add(0, 0, 19, 32'h1000, ALU_ADD, CFU_NONE, 1, 1, 1);    // auipc
        add(0, 0, 20, 32'h1234_5000, ALU_PASSB, CFU_NONE, 0, 1, 1);
        // Dependent chain at distances 1, 2 and 3.
        add(20, 0, 21, 1, ALU_ADD, CFU_NONE, 0, 1, 1);
        add(21, 20, 22, 0, ALU_ADD, CFU_NONE, 0, 0, 1);
        add(20, 22, 23, 0, ALU_ADD, CFU_NONE, 0, 0, 1);
        add(21, 23, 24, 0, ALU_SUB, CFU_NONE, 0, 0, 1);
        add(0, 0, 25, 99, ALU_ADD, CFU_NONE, 0, 1, 0);
        add(25, 0, 26, 0, ALU_ADD, CFU_NONE, 0, 1, 1);
        // Branch conditions and jump.
        add(1, 1, 0, 16, ALU_ADD, CFU_EQ, 1, 1, 0);
        add(1, 2, 0, -8, ALU_ADD, CFU_EQ, 1, 1, 0);
        add(1, 2, 0, 24, ALU_ADD, CFU_NE, 1, 1, 0);
        add(1, 1, 0, 28, ALU_ADD, CFU_NE, 1, 1, 0);
        add(2, 1, 0, -32, ALU_ADD, CFU_LT, 1, 1, 0);
        add(1, 2, 0, 40, ALU_ADD, CFU_LT, 1, 1, 0);
        add(1, 2, 0, 12, ALU_ADD, CFU_GE, 1, 1, 0);
        add(2, 2, 0, -4, ALU_ADD, CFU_GE, 1, 1, 0);
        add(2, 1, 0, 36, ALU_ADD, CFU_GE, 1, 1, 0);
        add(2, 1, 0, 8, ALU_ADD, CFU_LTU, 1, 1, 0);
        add(1, 2, 0, 64, ALU_ADD, CFU_LTU, 1, 1, 0);
        add(2, 1, 0, -128, ALU_ADD, CFU_GEU, 1, 1, 0);
        add(0, 0, 27, 32'h40, ALU_ADD, CFU_JUMP, 1, 1, 1);
        add(27, 0, 28, 4, ALU_ADD, CFU_NONE, 0, 1, 1);
        add(27, 28, 0, 20, ALU_ADD, CFU_GEU, 1, 1, 0);
        run_model();
        limit        = tbl.size() * 8 + 50;
        credits      = `IN_DEPTH;
        out_avail    = `OUT_CREDITS;
        cyc          = 0;
        send_idx     = 0;
        rcv_cnt      = 0;
        credit_total = 0;
        settle       = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (settle < 10)
        begin
            @(negedge clk);
            step_cycle();
            if (rcv_cnt == tbl.size())
                settle++;
        end
        check_val("input credit pulses", 32'(credit_total), 32'(tbl.size()));
        check_val("sender credits at end", 32'(credits), 32'(`IN_DEPTH));
        check_val("output credits at end", 32'(out_avail), 32'(`OUT_CREDITS));
        $display("sim passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/credit_fifo.sv
design/alu.sv
design/cfu.sv
design/id_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/mini_core.sv
sim/tb_mini_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mini_core
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
